// File: common/xlat_pkg.sv
/* slave translator shared definitions
   bus widths, wait-state timing and the timer phase encoding */

`default_nettype none

package xlat_pkg;

   // ------------------------------------------------------------------------
   // widths
   // ------------------------------------------------------------------------
   localparam int UAV_ADDRESS_W    = 32;   // byte address, interconnect side
   localparam int AV_ADDRESS_W     = 30;   // word address, slave side
   localparam int WORD_SHIFT       = 2;    // bytes to words
   localparam int DATA_W           = 32;
   localparam int BYTEENABLE_W     = 4;
   localparam int SYMBOLS_PER_WORD = 4;    // also the byte burstcount of a last beat
   localparam int UAV_BURSTCOUNT_W = 6;    // in bytes
   localparam int AV_BURSTCOUNT_W  = 4;    // in words

   // ------------------------------------------------------------------------
   // slave timing
   // ------------------------------------------------------------------------
   // setup cycles pass with both strobes low
   localparam int SETUP_CYCLES      = 1;
   // read strobe cycles before the read is taken
   localparam int READ_WAIT_CYCLES  = 2;
   localparam int WRITE_WAIT_CYCLES = 2;   // write strobe length
   // data stays on the bus this long after write falls
   localparam int HOLD_CYCLES       = 1;
   localparam int READ_LATENCY      = 2;   // read accept to readdatavalid

   // phase counter, wide enough for the longest phase
   localparam int WAIT_COUNT_W      = 3;

   // ------------------------------------------------------------------------
   // timer phases
   // ------------------------------------------------------------------------
   // PH_IDLE   single dead cycle after reset
   // PH_SETUP  resting phase, counts setup cycles once a request shows up
   // PH_ACCESS strobe high
   // PH_HOLD   write data hold, strobe low
   // PH_DONE   waitrequest low, request taken at the next edge
   typedef enum logic [2:0] {
      PH_IDLE,
      PH_SETUP,
      PH_ACCESS,
      PH_HOLD,
      PH_DONE
   } wait_phase_e;

endpackage

`default_nettype wire

// File: hdl/wait_state_timer.sv
/* wait-state timer
   walks setup, access and hold phases, drives slave strobes and waitrequest */

`timescale 1ns/10ps
`default_nettype none

module wait_state_timer
   import xlat_pkg::*;
(
   input  wire   clk,
   input  wire   reset,
   input  wire   uav_read,
   input  wire   uav_write,
   output logic  av_read,
   output logic  av_write,
   output logic  uav_waitrequest,
   output logic  accept
);

   wait_phase_e              wait_phase;
   wait_phase_e              wait_phase_next;
   logic [WAIT_COUNT_W-1:0]  phase_count;
   logic [WAIT_COUNT_W-1:0]  phase_count_next;
   logic [WAIT_COUNT_W-1:0]  access_last;
   logic                     request;

   assign request     = uav_read | uav_write;
   assign access_last = uav_write ? WAIT_COUNT_W'(WRITE_WAIT_CYCLES - 1)
                                  : WAIT_COUNT_W'(READ_WAIT_CYCLES - 1);

   // ------------------------------------------------------------------------
   // phase sequencing
   // ------------------------------------------------------------------------
   always_comb begin
      wait_phase_next  = wait_phase;
      phase_count_next = phase_count + 1'b1;
      if (wait_phase != PH_IDLE && !request) begin
         wait_phase_next  = PH_SETUP;   // request gone, start over
         phase_count_next = '0;
      end else begin
         case (wait_phase)
            PH_IDLE: begin
               wait_phase_next  = PH_SETUP;
               phase_count_next = '0;
            end
            PH_SETUP: begin
               if (phase_count == WAIT_COUNT_W'(SETUP_CYCLES - 1)) begin
                  wait_phase_next  = PH_ACCESS;
                  phase_count_next = '0;
               end
            end
            PH_ACCESS: begin
               if (phase_count == access_last) begin
                  wait_phase_next  = uav_write ? PH_HOLD : PH_DONE;
                  phase_count_next = '0;
               end
            end
            PH_HOLD: begin
               if (phase_count == WAIT_COUNT_W'(HOLD_CYCLES - 1)) begin
                  wait_phase_next  = PH_DONE;
                  phase_count_next = '0;
               end
            end
            default: begin   // PH_DONE, next request counts from scratch
               wait_phase_next  = PH_SETUP;
               phase_count_next = '0;
            end
         endcase
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_phase  <= PH_IDLE;
         phase_count <= '0;
      end else begin
         wait_phase  <= wait_phase_next;
         phase_count <= phase_count_next;
      end
   end

   // read strobe stays up into the accept cycle, write drops for the hold
   assign av_read  = uav_read & (wait_phase == PH_ACCESS || wait_phase == PH_DONE);
   assign av_write = uav_write & (wait_phase == PH_ACCESS);

   assign uav_waitrequest = (wait_phase != PH_DONE);   // high in PH_IDLE after reset
   assign accept          = request & ~uav_waitrequest;

endmodule

`default_nettype wire

// File: hdl/transfer_markers.sv
/* transfer markers
   begintransfer and beginbursttransfer, plus constant burst address and count */

`timescale 1ns/10ps
`default_nettype none

module transfer_markers
   import xlat_pkg::*;
(
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          uav_read,
   input  wire                          uav_write,
   input  wire                          accept,
   input  wire  [UAV_BURSTCOUNT_W-1:0]  uav_burstcount,
   input  wire  [AV_ADDRESS_W-1:0]      word_address,
   input  wire  [AV_BURSTCOUNT_W-1:0]   word_burstcount,
   output logic                         av_begintransfer,
   output logic                         av_beginbursttransfer,
   output logic [AV_ADDRESS_W-1:0]      av_address,
   output logic [AV_BURSTCOUNT_W-1:0]   av_burstcount
);

   logic                        request;
   logic                        begin_seen;   // begintransfer already given
   logic                        in_burst;     // later beats of a write burst
   logic                        last_beat;
   logic [AV_ADDRESS_W-1:0]     address_hold;
   logic [AV_BURSTCOUNT_W-1:0]  burstcount_hold;

   assign request   = uav_read | uav_write;
   assign last_beat = (uav_burstcount == UAV_BURSTCOUNT_W'(SYMBOLS_PER_WORD));

   // ------------------------------------------------------------------------
   // begin markers
   // ------------------------------------------------------------------------
   assign av_begintransfer = request & ~begin_seen;

   // a read is a whole burst in one request
   assign av_beginbursttransfer = uav_read ? av_begintransfer
                                           : av_begintransfer & ~in_burst;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         begin_seen <= 1'b0;
         in_burst   <= 1'b0;
      end else begin
         if (accept) begin
            begin_seen <= 1'b0;
         end else if (av_begintransfer) begin
            begin_seen <= 1'b1;
         end

         // last beat carries one word of bytes
         if (accept && uav_write) begin
            in_burst <= ~last_beat;
         end
      end
   end

   // ------------------------------------------------------------------------
   // constant burst fields
   // ------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (av_beginbursttransfer) begin
         address_hold    <= word_address;
         burstcount_hold <= word_burstcount;
      end
   end

   // interconnect steps address and count per beat, slave wants first beat's
   always_comb begin
      av_address    = word_address;
      av_burstcount = word_burstcount;
      if (uav_write && in_burst) begin
         av_address    = address_hold;
         av_burstcount = burstcount_hold;
      end
   end

endmodule

`default_nettype wire

// File: hdl/read_return.sv
/* read return path
   read-latency pipeline for readdatavalid and the pending-read flag */

`timescale 1ns/10ps
`default_nettype none

module read_return
   import xlat_pkg::*;
(
   input  wire   clk,
   input  wire   reset,
   input  wire   uav_read,
   input  wire   accept,
   output logic  uav_readdatavalid,
   output logic  read_pending
);

   // one bit per cycle of latency, bit 0 is the cycle after acceptance
   logic [READ_LATENCY-1:0]  read_stage;

   // ------------------------------------------------------------------------
   // latency pipeline
   // ------------------------------------------------------------------------
   // back-to-back reads just occupy separate stages
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         read_stage <= '0;
      end else begin
         read_stage[0] <= accept & uav_read;
         for (int i = 1; i < READ_LATENCY; i++) begin
            read_stage[i] <= read_stage[i-1];
         end
      end
   end

   // slave data is valid in the top stage cycle
   assign uav_readdatavalid = read_stage[READ_LATENCY-1];

   // keeps chipselect up until the last data returns
   assign read_pending = |read_stage;

endmodule

`default_nettype wire

// File: hdl/mm_slave_translator.sv
/* memory-mapped slave translator top
   byte-addressed interconnect requests to a fixed-timing word-addressed slave */

`timescale 1ns/10ps
`default_nettype none

module mm_slave_translator
   import xlat_pkg::*;
(
   input  wire                          clk,
   input  wire                          reset,

   // interconnect side
   input  wire  [UAV_ADDRESS_W-1:0]     uav_address,
   input  wire  [DATA_W-1:0]            uav_writedata,
   input  wire                          uav_read,
   input  wire                          uav_write,
   input  wire  [UAV_BURSTCOUNT_W-1:0]  uav_burstcount,
   input  wire  [BYTEENABLE_W-1:0]      uav_byteenable,
   output logic                         uav_waitrequest,
   output logic [DATA_W-1:0]            uav_readdata,
   output logic                         uav_readdatavalid,

   // slave side
   output logic [AV_ADDRESS_W-1:0]      av_address,
   output logic [DATA_W-1:0]            av_writedata,
   output logic                         av_read,
   output logic                         av_write,
   output logic [AV_BURSTCOUNT_W-1:0]   av_burstcount,
   output logic [BYTEENABLE_W-1:0]      av_byteenable,
   output logic [BYTEENABLE_W-1:0]      av_writebyteenable,
   output logic                         av_begintransfer,
   output logic                         av_beginbursttransfer,
   output logic                         av_chipselect,
   input  wire  [DATA_W-1:0]            av_readdata
);

   logic                        accept;
   logic                        read_pending;
   logic [AV_ADDRESS_W-1:0]     word_address;
   logic [AV_BURSTCOUNT_W-1:0]  word_burstcount;

   // ------------------------------------------------------------------------
   // byte to word conversion and pass-through fields
   // ------------------------------------------------------------------------
   assign word_address    = uav_address[UAV_ADDRESS_W-1:WORD_SHIFT];
   assign word_burstcount = uav_burstcount[UAV_BURSTCOUNT_W-1:WORD_SHIFT];

   assign av_writedata       = uav_writedata;
   assign av_byteenable      = uav_byteenable;
   assign av_writebyteenable = {BYTEENABLE_W{uav_write}} & uav_byteenable;  // zero on reads
   assign uav_readdata       = av_readdata;   // qualified by readdatavalid

   // select held through the read latency
   assign av_chipselect = uav_read | uav_write | read_pending;

   // ------------------------------------------------------------------------
   // blocks
   // ------------------------------------------------------------------------
   wait_state_timer wait_state_timer_i (
      .clk             (clk),
      .reset           (reset),
      .uav_read        (uav_read),
      .uav_write       (uav_write),
      .av_read         (av_read),
      .av_write        (av_write),
      .uav_waitrequest (uav_waitrequest),
      .accept          (accept)
   );

   transfer_markers transfer_markers_i (
      .clk                   (clk),
      .reset                 (reset),
      .uav_read              (uav_read),
      .uav_write             (uav_write),
      .accept                (accept),
      .uav_burstcount        (uav_burstcount),
      .word_address          (word_address),
      .word_burstcount       (word_burstcount),
      .av_begintransfer      (av_begintransfer),
      .av_beginbursttransfer (av_beginbursttransfer),
      .av_address            (av_address),
      .av_burstcount         (av_burstcount)
   );

   read_return read_return_i (
      .clk               (clk),
      .reset             (reset),
      .uav_read          (uav_read),
      .accept            (accept),
      .uav_readdatavalid (uav_readdatavalid),
      .read_pending      (read_pending)
   );

endmodule

`default_nettype wire

// File: tests/tb_stimulus.svh
/* translator testbench stimulus
   transaction table and the expected-value rules for each request */

`ifndef TB_STIMULUS_SVH
`define TB_STIMULUS_SVH

typedef enum logic {
   OP_READ,
   OP_WRITE
} tb_op_e;

typedef struct packed {
   tb_op_e       op;
   logic [31:0]  address;      // byte address of the first beat
   logic [3:0]   beats;        // words in the burst, reads use one
   logic [3:0]   byteenable;
   logic [31:0]  writedata;    // first beat only, later beats are random
} transaction_t;

localparam int TABLE_LEN = 12;

// op        address        beats  be     writedata
localparam transaction_t TRANSACTIONS [TABLE_LEN] = '{
   '{OP_WRITE, 32'h0000_0100, 4'd1, 4'hF, 32'h1234_5678},
   '{OP_READ,  32'h0000_0100, 4'd1, 4'hF, 32'h0000_0000},
   '{OP_READ,  32'h0000_0204, 4'd1, 4'hF, 32'h0000_0000},
   '{OP_READ,  32'h0001_0008, 4'd1, 4'hF, 32'h0000_0000},
   '{OP_WRITE, 32'h0000_0400, 4'd4, 4'hF, 32'hCAFE_0001},
   '{OP_WRITE, 32'h0000_0800, 4'd2, 4'h3, 32'h0BAD_F00D},
   '{OP_READ,  32'hFFFF_FFFC, 4'd1, 4'hF, 32'h0000_0000},
   '{OP_WRITE, 32'h8000_0010, 4'd1, 4'hC, 32'hA5A5_5A5A},
   '{OP_READ,  32'h1234_5670, 4'd1, 4'hF, 32'h0000_0000},
   '{OP_WRITE, 32'h0000_0040, 4'd3, 4'h6, 32'hDEAD_BEEF},
   '{OP_READ,  32'h0000_0040, 4'd1, 4'hF, 32'h0000_0000},
   '{OP_READ,  32'h7FFF_FFF0, 4'd1, 4'hF, 32'h0000_0000}
};

// setup, strobe, (hold,) then the accept cycle
function automatic int request_cycles(input tb_op_e op);
   return (op == OP_READ) ? 4 : 5;
endfunction

// byte address or byte count in words
function automatic logic [31:0] to_words(input logic [31:0] byte_value);
   return byte_value >> 2;
endfunction

// slave contents, every address bit shows in the data
function automatic logic [31:0] slave_word(input logic [31:0] word_address);
   return {word_address[29:0], 2'b01} ^ 32'h5A3C_96E1;
endfunction

`endif

// File: tests/mm_slave_translator_tb.sv
/* slave translator testbench
   table-driven requests, fixed-latency slave model and cycle checks */

`timescale 1ns/10ps
`default_nettype none

module mm_slave_translator_tb
   import xlat_pkg::*;
();

   `include "tb_stimulus.svh"

   localparam int CLK_PERIOD = 10;

   logic                         clk;
   logic                         reset;
   logic [UAV_ADDRESS_W-1:0]     uav_address;
   logic [DATA_W-1:0]            uav_writedata;
   logic                         uav_read;
   logic                         uav_write;
   logic [UAV_BURSTCOUNT_W-1:0]  uav_burstcount;
   logic [BYTEENABLE_W-1:0]      uav_byteenable;
   logic                         uav_waitrequest;
   logic [DATA_W-1:0]            uav_readdata;
   logic                         uav_readdatavalid;
   logic [AV_ADDRESS_W-1:0]      av_address;
   logic [DATA_W-1:0]            av_writedata;
   logic                         av_read;
   logic                         av_write;
   logic [AV_BURSTCOUNT_W-1:0]   av_burstcount;
   logic [BYTEENABLE_W-1:0]      av_byteenable;
   logic [BYTEENABLE_W-1:0]      av_writebyteenable;
   logic                         av_begintransfer;
   logic                         av_beginbursttransfer;
   logic                         av_chipselect;
   logic [DATA_W-1:0]            av_readdata = '0;

   logic [AV_ADDRESS_W-1:0]  read_addr_q1 = '0;   // slave model latency stages
   logic [AV_ADDRESS_W-1:0]  read_addr_q2 = '0;
   logic [15:0]              lfsr_state = 16'd56823;
   int                       cycle_no = 0;
   int                       last_valid_cycle = 0;
   int                       mismatch_count = 0;
   int                       failure_count = 0;
   int                       valid_cycle_q [$];
   logic [31:0]              read_data_q [$];

   mm_slave_translator mm_slave_translator_i (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(negedge clk) cycle_no++;   // stable at every rising edge

   // ------------------------------------------------------------------------
   // slave model with data two cycles behind the accepted address
   // ------------------------------------------------------------------------
   always @(posedge clk) begin
      read_addr_q1 <= av_address;
      read_addr_q2 <= read_addr_q1;
   end

   always @(negedge clk) av_readdata <= slave_word({2'b00, read_addr_q2});

   // ------------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------------
   function automatic logic [31:0] take_bits(input int count);
      logic [31:0]  value;
      logic         out_bit;
      value = '0;
      for (int i = 0; i < count; i++) begin
         out_bit    = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400;   // x^16 + x^14 + x^13 + x^11 + 1
         end
         value = {value[30:0], out_bit};
      end
      return value;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         mismatch_count++;
         $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
      end
   endtask

   task automatic report_failure(input string what);
      failure_count++;
      $display("Error at %0t: %s", $time, what);
   endtask

   task automatic idle_cycle();
      @(negedge clk);
      uav_read  = 1'b0;
      uav_write = 1'b0;
      @(posedge clk);
      check_value("av_read", 32'(av_read), 32'd0);
      check_value("av_write", 32'(av_write), 32'd0);
      check_value("av_begintransfer", 32'(av_begintransfer), 32'd0);
      check_value("av_chipselect", 32'(av_chipselect), 32'(cycle_no <= last_valid_cycle));
   endtask

   // one beat held until waitrequest is seen low
   task automatic run_beat(input transaction_t row, input int beat);
      logic [31:0]  data;
      int           count;
      int           len;
      logic         is_read;
      logic         accepted;
      logic         waiting;
      is_read  = (row.op == OP_READ);
      len      = request_cycles(row.op);
      data     = (beat == 0) ? row.writedata : take_bits(32);
      accepted = 1'b0;
      waiting  = 1'b1;
      count    = 0;
      @(negedge clk);
      uav_read       = is_read;
      uav_write      = !is_read;
      uav_address    = row.address + 32'(4 * beat);   // interconnect steps per beat
      uav_burstcount = 6'((row.beats - beat) * 4);
      uav_byteenable = row.byteenable;
      uav_writedata  = data;
      while (waiting) begin
         @(posedge clk);
         count++;
         check_value("uav_waitrequest", 32'(uav_waitrequest), 32'(count != len));
         check_value("av_read", 32'(av_read), 32'(is_read && count >= 2));
         check_value("av_write", 32'(av_write), 32'(!is_read && count >= 2 && count <= 3));
         check_value("av_begintransfer", 32'(av_begintransfer), 32'(count == 1));
         check_value("av_beginbursttransfer", 32'(av_beginbursttransfer),
                     32'(count == 1 && beat == 0));
         check_value("av_address", 32'(av_address), to_words(row.address));
         check_value("av_burstcount", 32'(av_burstcount), 32'(row.beats));
         check_value("av_byteenable", 32'(av_byteenable), 32'(row.byteenable));
         check_value("av_writebyteenable", 32'(av_writebyteenable),
                     is_read ? 32'd0 : 32'(row.byteenable));
         check_value("av_writedata", av_writedata, data);
         check_value("av_chipselect", 32'(av_chipselect), 32'd1);
         if (!uav_waitrequest) begin
            accepted = 1'b1;
            waiting  = 1'b0;
         end else if (count == 3 * len) begin
            report_failure("request was never accepted");
            waiting = 1'b0;
         end
      end
      if (is_read && accepted) begin
         last_valid_cycle = cycle_no + 2;
         valid_cycle_q.push_back(cycle_no + 2);
         read_data_q.push_back(slave_word(to_words(row.address)));
      end
   endtask

   // ------------------------------------------------------------------------
   // valid exactly two cycles after each read accept
   // ------------------------------------------------------------------------
   always @(posedge clk) begin : return_monitor
      logic expect_valid;
      expect_valid = (valid_cycle_q.size() > 0) && (valid_cycle_q[0] == cycle_no);
      check_value("uav_readdatavalid", 32'(uav_readdatavalid), 32'(expect_valid));
      if (expect_valid) begin
         check_value("uav_readdata", uav_readdata, read_data_q.pop_front());
         void'(valid_cycle_q.pop_front());
      end
   end

   // ------------------------------------------------------------------------
   // table loop
   // ------------------------------------------------------------------------
   initial begin
      tb_op_e  prev_op;
      int      gap;
      reset          = 1'b1;
      uav_address    = '0;
      uav_writedata  = '0;
      uav_read       = 1'b0;
      uav_write      = 1'b0;
      uav_burstcount = '0;
      uav_byteenable = '0;
      prev_op        = OP_WRITE;
      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(posedge clk);
      // first cycle out of reset
      check_value("uav_waitrequest", 32'(uav_waitrequest), 32'd1);
      check_value("av_read", 32'(av_read), 32'd0);
      check_value("av_write", 32'(av_write), 32'd0);
      check_value("av_begintransfer", 32'(av_begintransfer), 32'd0);
      check_value("av_beginbursttransfer", 32'(av_beginbursttransfer), 32'd0);
      for (int i = 0; i < TABLE_LEN; i++) begin
         // reads after reads go back to back to fill the pipeline
         if (TRANSACTIONS[i].op == OP_READ && prev_op == OP_READ) begin
            gap = 0;
         end else begin
            gap = int'(take_bits(2));
         end
         repeat (gap) idle_cycle();
         for (int b = 0; b < int'(TRANSACTIONS[i].beats); b++) begin
            run_beat(TRANSACTIONS[i], b);
         end
         prev_op = TRANSACTIONS[i].op;
      end
      repeat (4) idle_cycle();   // drain pending reads
      $display("Done: %0d mismatches, %0d other errors", mismatch_count, failure_count);
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // watchdog allows ten cycles per beat plus reset
   initial begin
      int total_beats;
      total_beats = 0;
      for (int i = 0; i < TABLE_LEN; i++) begin
         total_beats += int'(TRANSACTIONS[i].beats);
      end
      #((total_beats * 10 + 20) * CLK_PERIOD);
      $display("Timeout: the table did not finish in time");
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: mm_slave_translator.f
+incdir+tests
common/xlat_pkg.sv
hdl/wait_state_timer.sv
hdl/transfer_markers.sv
hdl/read_return.sv
hdl/mm_slave_translator.sv
tests/mm_slave_translator_tb.sv

// File: Bender.yml
package:
  name: mm_slave_translator

sources:
  - common/xlat_pkg.sv
  - hdl/wait_state_timer.sv
  - hdl/transfer_markers.sv
  - hdl/read_return.sv
  - hdl/mm_slave_translator.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/mm_slave_translator_tb.sv
